//--- verilog/smartnic_app_pkg.sv
package smartnic_app_pkg;

    // ------------------------------------------------------------
    // Stream widths and types
    // ------------------------------------------------------------
    localparam int AXIS_DATA_BYTE_WID = 8;
    localparam int AXIS_DATA_WID      = AXIS_DATA_BYTE_WID * 8;

    typedef logic [3:0] port_t;

    typedef struct packed {
        logic [15:0] pid;
    } tuser_meta_t;

    // One AXI-Stream beat without the handshake
    typedef struct packed {
        logic [AXIS_DATA_WID-1:0]      tdata;
        logic [AXIS_DATA_BYTE_WID-1:0] tkeep;
        logic                          tlast;
        port_t                         tid;
        port_t                         tdest;
        tuser_meta_t                   tuser;
    } axis_beat_t;

    // Forces the ingress demux to one output when enabled
    typedef struct packed {
        logic enable;
        logic value;
    } demux_override_t;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    localparam int REG_ADDR_WID = 4;
    localparam int REG_DATA_WID = 32;

    typedef logic [REG_ADDR_WID-1:0] reg_addr_t;

    localparam reg_addr_t REG_IGR_DEMUX_SEL = 4'h0;

    // Field positions in REG_IGR_DEMUX_SEL
    localparam int IGR_DEMUX_SEL_ENABLE_BIT = 0;
    localparam int IGR_DEMUX_SEL_VALUE_BIT  = 1;

    localparam int FIFO_DEPTH_DEFAULT = 8;

endpackage

//--- verilog/app_ctrl.sv
`timescale 1ns/1ps

module app_ctrl (
    input  logic                                      core_clk,
    input  logic                                      reset,

    // Register write strobe and combinational read
    input  logic                                      reg_wr,
    input  smartnic_app_pkg::reg_addr_t               reg_addr,
    input  logic [smartnic_app_pkg::REG_DATA_WID-1:0] reg_wdata,
    output logic [smartnic_app_pkg::REG_DATA_WID-1:0] reg_rdata,

    // Steering control towards the ingress demux
    output smartnic_app_pkg::demux_override_t         demux_override
);
    import smartnic_app_pkg::*;

    demux_override_t igr_demux_sel;
    logic            igr_demux_sel_wr;

    // ------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------
    assign igr_demux_sel_wr = reg_wr && (reg_addr == REG_IGR_DEMUX_SEL);

    always_ff @(posedge core_clk) begin
        if (reset) begin
            igr_demux_sel <= '0;
        end else if (igr_demux_sel_wr) begin
            igr_demux_sel.enable <= reg_wdata[IGR_DEMUX_SEL_ENABLE_BIT];
            igr_demux_sel.value  <= reg_wdata[IGR_DEMUX_SEL_VALUE_BIT];
        end
    end

    // ------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------
    // Unmapped addresses read as zero
    always_comb begin
        reg_rdata = '0;
        if (reg_addr == REG_IGR_DEMUX_SEL) begin
            reg_rdata[IGR_DEMUX_SEL_ENABLE_BIT] = igr_demux_sel.enable;
            reg_rdata[IGR_DEMUX_SEL_VALUE_BIT]  = igr_demux_sel.value;
        end
    end

    assign demux_override = igr_demux_sel;

endmodule

//--- verilog/axis_fifo_sync.sv
`timescale 1ns/1ps

module axis_fifo_sync #(
    parameter int DEPTH = 8
) (
    input  logic                         core_clk,
    input  logic                         reset,

    // Write side
    input  smartnic_app_pkg::axis_beat_t in_beat,
    input  logic                         in_tvalid,
    output logic                         in_tready,

    // Read side
    output smartnic_app_pkg::axis_beat_t out_beat,
    output logic                         out_tvalid,
    input  logic                         out_tready
);
    import smartnic_app_pkg::*;

    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = PTR_WID + 1;

    axis_beat_t         mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [CNT_WID-1:0] count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    // ------------------------------------------------------------
    // Status and handshake
    // ------------------------------------------------------------
    assign full  = (count == CNT_WID'(DEPTH));
    assign empty = (count == '0);

    // Ready depends on occupancy only
    assign in_tready  = !full;
    assign out_tvalid = !empty;

    assign push = in_tvalid && in_tready;
    assign pop  = out_tvalid && out_tready;

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    assign out_beat = mem[rd_ptr];

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge core_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- verilog/axis_demux.sv
`timescale 1ns/1ps

module axis_demux (
    input  logic                              core_clk,
    input  logic                              reset,
    input  smartnic_app_pkg::demux_override_t demux_override,

    input  smartnic_app_pkg::axis_beat_t      in_beat,
    input  logic                              in_tvalid,
    output logic                              in_tready,

    output smartnic_app_pkg::axis_beat_t      out0_beat,
    output logic                              out0_tvalid,
    input  logic                              out0_tready,

    output smartnic_app_pkg::axis_beat_t      out1_beat,
    output logic                              out1_tvalid,
    input  logic                              out1_tready
);

    logic pkt_active;
    logic sel_q;
    logic sel_new;
    logic sel;

    // Register override wins over the packet's own tdest
    assign sel_new = demux_override.enable ? demux_override.value : in_beat.tdest[0];

    // Held from the first offered beat until tlast leaves
    assign sel = pkt_active ? sel_q : sel_new;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            pkt_active <= 1'b0;
            sel_q      <= 1'b0;
        end else begin
            if (in_tvalid && in_tready && in_beat.tlast) begin
                pkt_active <= 1'b0;
            end else if (in_tvalid) begin
                pkt_active <= 1'b1;
            end
            if (!pkt_active && in_tvalid) begin
                sel_q <= sel_new;
            end
        end
    end

    // Data fans out and only the selected side sees valid
    assign out0_beat   = in_beat;
    assign out1_beat   = in_beat;
    assign out0_tvalid = in_tvalid && !sel;
    assign out1_tvalid = in_tvalid && sel;
    assign in_tready   = sel ? out1_tready : out0_tready;

endmodule

//--- verilog/axis_mux.sv
`timescale 1ns/1ps

module axis_mux (
    input  logic                         core_clk,
    input  logic                         reset,

    input  smartnic_app_pkg::axis_beat_t in0_beat,
    input  logic                         in0_tvalid,
    output logic                         in0_tready,

    input  smartnic_app_pkg::axis_beat_t in1_beat,
    input  logic                         in1_tvalid,
    output logic                         in1_tready,

    output smartnic_app_pkg::axis_beat_t out_beat,
    output logic                         out_tvalid,
    input  logic                         out_tready
);

    logic locked;
    logic grant;
    logic last_grant;
    logic grant_sel;
    logic out_xfer;

    // ------------------------------------------------------------
    // Arbitration
    // ------------------------------------------------------------
    // Round robin between packets with the grant held while locked
    always_comb begin
        if (locked) begin
            grant_sel = grant;
        end else if (in0_tvalid && in1_tvalid) begin
            grant_sel = !last_grant;
        end else if (in1_tvalid) begin
            grant_sel = 1'b1;
        end else begin
            grant_sel = 1'b0;
        end
    end

    assign out_xfer = out_tvalid && out_tready;

    // last_grant starts at 1 so input 0 wins the first tie
    always_ff @(posedge core_clk) begin
        if (reset) begin
            locked     <= 1'b0;
            grant      <= 1'b0;
            last_grant <= 1'b1;
        end else begin
            // Lock as soon as a beat is offered so the output holds steady
            if (out_xfer && out_beat.tlast) begin
                locked <= 1'b0;
            end else if (out_tvalid) begin
                locked <= 1'b1;
            end
            if (!locked && out_tvalid) begin
                grant <= grant_sel;
            end
            if (out_xfer && out_beat.tlast) begin
                last_grant <= grant_sel;
            end
        end
    end

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    assign out_beat   = grant_sel ? in1_beat : in0_beat;
    assign out_tvalid = grant_sel ? in1_tvalid : in0_tvalid;

    // Ungranted input is stalled
    assign in0_tready = !grant_sel && out_tready;
    assign in1_tready = grant_sel && out_tready;

endmodule

//--- verilog/smartnic_app.sv
`timescale 1ns/1ps

module smartnic_app #(
    parameter int FIFO_DEPTH = smartnic_app_pkg::FIFO_DEPTH_DEFAULT
) (
    input  logic                                      core_clk,
    input  logic                                      reset,

    // Register port
    input  logic                                      reg_wr,
    input  smartnic_app_pkg::reg_addr_t               reg_addr,
    input  logic [smartnic_app_pkg::REG_DATA_WID-1:0] reg_wdata,
    output logic [smartnic_app_pkg::REG_DATA_WID-1:0] reg_rdata,

    // App ingress stream
    input  smartnic_app_pkg::axis_beat_t              app_igr_beat,
    input  logic                                      app_igr_tvalid,
    output logic                                      app_igr_tready,

    // Host to card stream
    input  smartnic_app_pkg::axis_beat_t              h2c_beat,
    input  logic                                      h2c_tvalid,
    output logic                                      h2c_tready,

    // App egress stream
    output smartnic_app_pkg::axis_beat_t              app_egr_beat,
    output logic                                      app_egr_tvalid,
    input  logic                                      app_egr_tready,

    // Card to host stream
    output smartnic_app_pkg::axis_beat_t              c2h_beat,
    output logic                                      c2h_tvalid,
    input  logic                                      c2h_tready
);
    import smartnic_app_pkg::*;

    demux_override_t demux_override;

    // Internal streams
    axis_beat_t igr_fifo_beat;
    logic       igr_fifo_tvalid, igr_fifo_tready;
    axis_beat_t demux0_beat;
    logic       demux0_tvalid, demux0_tready;
    axis_beat_t demux1_beat;
    logic       demux1_tvalid, demux1_tready;
    axis_beat_t h2c_fifo_beat;
    logic       h2c_fifo_tvalid, h2c_fifo_tready;
    axis_beat_t mux_beat;
    logic       mux_tvalid, mux_tready;

    // ------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------
    app_ctrl app_ctrl_i (
        .core_clk       ( core_clk ),
        .reset          ( reset ),
        .reg_wr         ( reg_wr ),
        .reg_addr       ( reg_addr ),
        .reg_wdata      ( reg_wdata ),
        .reg_rdata      ( reg_rdata ),
        .demux_override ( demux_override )
    );

    // ------------------------------------------------------------
    // Ingress path
    // ------------------------------------------------------------
    axis_fifo_sync #(.DEPTH(FIFO_DEPTH)) igr_fifo (
        .core_clk ( core_clk ), .reset ( reset ),
        .in_beat  ( app_igr_beat ),  .in_tvalid  ( app_igr_tvalid ),  .in_tready  ( app_igr_tready ),
        .out_beat ( igr_fifo_beat ), .out_tvalid ( igr_fifo_tvalid ), .out_tready ( igr_fifo_tready )
    );

    axis_demux axis_demux_i (
        .core_clk       ( core_clk ),
        .reset          ( reset ),
        .demux_override ( demux_override ),
        .in_beat        ( igr_fifo_beat ), .in_tvalid   ( igr_fifo_tvalid ),
        .in_tready      ( igr_fifo_tready ),
        .out0_beat      ( demux0_beat ),   .out0_tvalid ( demux0_tvalid ),
        .out0_tready    ( demux0_tready ),
        .out1_beat      ( demux1_beat ),   .out1_tvalid ( demux1_tvalid ),
        .out1_tready    ( demux1_tready )
    );

    // Demux output 1 leaves towards the host
    axis_fifo_sync #(.DEPTH(FIFO_DEPTH)) c2h_fifo (
        .core_clk ( core_clk ), .reset ( reset ),
        .in_beat  ( demux1_beat ), .in_tvalid  ( demux1_tvalid ), .in_tready  ( demux1_tready ),
        .out_beat ( c2h_beat ),    .out_tvalid ( c2h_tvalid ),    .out_tready ( c2h_tready )
    );

    // ------------------------------------------------------------
    // Egress path
    // ------------------------------------------------------------
    axis_fifo_sync #(.DEPTH(FIFO_DEPTH)) h2c_fifo (
        .core_clk ( core_clk ), .reset ( reset ),
        .in_beat  ( h2c_beat ),      .in_tvalid  ( h2c_tvalid ),      .in_tready  ( h2c_tready ),
        .out_beat ( h2c_fifo_beat ), .out_tvalid ( h2c_fifo_tvalid ), .out_tready ( h2c_fifo_tready )
    );

    axis_mux axis_mux_i (
        .core_clk   ( core_clk ),
        .reset      ( reset ),
        .in0_beat   ( demux0_beat ),   .in0_tvalid ( demux0_tvalid ),
        .in0_tready ( demux0_tready ),
        .in1_beat   ( h2c_fifo_beat ), .in1_tvalid ( h2c_fifo_tvalid ),
        .in1_tready ( h2c_fifo_tready ),
        .out_beat   ( mux_beat ),      .out_tvalid ( mux_tvalid ),
        .out_tready ( mux_tready )
    );

    axis_fifo_sync #(.DEPTH(FIFO_DEPTH)) egr_fifo (
        .core_clk ( core_clk ), .reset ( reset ),
        .in_beat  ( mux_beat ),     .in_tvalid  ( mux_tvalid ),     .in_tready  ( mux_tready ),
        .out_beat ( app_egr_beat ), .out_tvalid ( app_egr_tvalid ), .out_tready ( app_egr_tready )
    );

endmodule

//--- verif/smartnic_app_chk.sv
`timescale 1ns/1ps

module smartnic_app_chk (
    input logic                                      core_clk,
    input logic                                      reset,
    input logic [smartnic_app_pkg::REG_DATA_WID-1:0] reg_rdata,
    input smartnic_app_pkg::axis_beat_t              app_egr_beat,
    input logic                                      app_egr_tvalid,
    input logic                                      app_egr_tready,
    input smartnic_app_pkg::axis_beat_t              c2h_beat,
    input logic                                      c2h_tvalid,
    input logic                                      c2h_tready
);
    import smartnic_app_pkg::*;

    int unsigned error_count = 0;

    // Packet in progress at app_egr and its source
    logic  egr_in_pkt;
    port_t egr_pkt_tid;

    always_ff @(posedge core_clk) begin
        if (reset) begin
            egr_in_pkt  <= 1'b0;
            egr_pkt_tid <= '0;
        end else if (app_egr_tvalid && app_egr_tready) begin
            egr_in_pkt  <= !app_egr_beat.tlast;
            egr_pkt_tid <= app_egr_beat.tid;
        end
    end

    // ------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------
    outputs_idle_after_reset: assert property (@(posedge core_clk)
        reset |=> !app_egr_tvalid && !c2h_tvalid)
        else begin
            $error("output valid high right after reset");
            error_count++;
        end

    reg_zero_after_reset: assert property (@(posedge core_clk)
        reset |=> reg_rdata == '0)
        else begin
            $error("register read not zero right after reset");
            error_count++;
        end

    // ------------------------------------------------------------
    // Stream protocol at the outputs
    // ------------------------------------------------------------
    egr_held_while_stalled: assert property (@(posedge core_clk) disable iff (reset)
        app_egr_tvalid && !app_egr_tready |=> app_egr_tvalid && $stable(app_egr_beat))
        else begin
            $error("app_egr beat changed while stalled");
            error_count++;
        end

    c2h_held_while_stalled: assert property (@(posedge core_clk) disable iff (reset)
        c2h_tvalid && !c2h_tready |=> c2h_tvalid && $stable(c2h_beat))
        else begin
            $error("c2h beat changed while stalled");
            error_count++;
        end

    // No beat of the other source before the tlast
    egr_no_interleave: assert property (@(posedge core_clk) disable iff (reset)
        egr_in_pkt && app_egr_tvalid && app_egr_tready |-> app_egr_beat.tid == egr_pkt_tid)
        else begin
            $error("app_egr packets interleaved");
            error_count++;
        end

endmodule

//--- verif/smartnic_app_tb.sv
`timescale 1ns/1ps

module smartnic_app_tb;
    import smartnic_app_pkg::*;

    localparam int CYCLE_LIMIT = 6000;

    logic                    core_clk;
    logic                    reset;
    logic                    reg_wr;
    reg_addr_t               reg_addr;
    logic [REG_DATA_WID-1:0] reg_wdata;
    logic [REG_DATA_WID-1:0] reg_rdata;
    axis_beat_t              app_igr_beat;
    logic                    app_igr_tvalid;
    logic                    app_igr_tready;
    axis_beat_t              h2c_beat;
    logic                    h2c_tvalid;
    logic                    h2c_tready;
    axis_beat_t              app_egr_beat;
    logic                    app_egr_tvalid;
    logic                    app_egr_tready;
    axis_beat_t              c2h_beat;
    logic                    c2h_tvalid;
    logic                    c2h_tready;

    logic [31:0]     lcg_state   = 32'd41341;
    int unsigned     cycle_count = 0;
    demux_override_t ovr;

    // Expected beats with app_egr split by source since sources interleave by packet
    axis_beat_t egr_igr_q[$];
    axis_beat_t egr_h2c_q[$];
    axis_beat_t c2h_q[$];

    smartnic_app #(.FIFO_DEPTH(FIFO_DEPTH_DEFAULT)) smartnic_app_i (.*);

    bind smartnic_app smartnic_app_chk smartnic_app_chk_i (
        .core_clk       ( core_clk ),
        .reset          ( reset ),
        .reg_rdata      ( reg_rdata ),
        .app_egr_beat   ( app_egr_beat ),
        .app_egr_tvalid ( app_egr_tvalid ),
        .app_egr_tready ( app_egr_tready ),
        .c2h_beat       ( c2h_beat ),
        .c2h_tvalid     ( c2h_tvalid ),
        .c2h_tready     ( c2h_tready )
    );

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Middle bit since the low bits of an LCG cycle too fast
    function automatic logic coin_flip();
        logic [31:0] r;
        r = next_rand();
        return r[16];
    endfunction

    task automatic report_fail(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopping after first error");
    endtask

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        report_fail($sformatf("Mismatch at time %0t: %s expected %h actual %h",
                              $time, name, exp, act));
    endtask

    task automatic check_egr_beat();
        axis_beat_t exp;
        if (app_egr_beat.tid == 4'd1) begin
            assert (egr_h2c_q.size() > 0)
                else report_fail("app_egr delivered an h2c beat that was never sent");
            exp = egr_h2c_q.pop_front();
        end else begin
            assert (egr_igr_q.size() > 0)
                else report_fail("app_egr delivered an app_igr beat that was never sent");
            exp = egr_igr_q.pop_front();
        end
        assert (app_egr_beat == exp) else report_mismatch("app_egr_beat", exp, app_egr_beat);
    endtask

    task automatic check_c2h_beat();
        axis_beat_t exp;
        assert (c2h_q.size() > 0) else report_fail("c2h delivered a beat that was never sent");
        exp = c2h_q.pop_front();
        assert (c2h_beat == exp) else report_mismatch("c2h_beat", exp, c2h_beat);
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [REG_DATA_WID-1:0] data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_wr    = 1'b1;
        @(posedge core_clk);
        #5;
        reg_wr = 1'b0;
        if (addr == REG_IGR_DEMUX_SEL) begin
            ovr.enable = data[IGR_DEMUX_SEL_ENABLE_BIT];
            ovr.value  = data[IGR_DEMUX_SEL_VALUE_BIT];
        end
    endtask

    task automatic check_reg(input logic [REG_DATA_WID-1:0] exp);
        reg_addr = REG_IGR_DEMUX_SEL;
        @(posedge core_clk);
        assert (reg_rdata == exp) else report_mismatch("reg_rdata", exp, reg_rdata);
        #5;
    endtask

    task automatic drive_beat(input logic from_h2c, input axis_beat_t beat);
        logic ready;
        // Idle cycles before the beat about half the time
        while (coin_flip()) begin
            @(posedge core_clk);
            #5;
        end
        if (from_h2c) begin
            h2c_beat   = beat;
            h2c_tvalid = 1'b1;
        end else begin
            app_igr_beat   = beat;
            app_igr_tvalid = 1'b1;
        end
        do begin
            @(posedge core_clk);
            ready = from_h2c ? h2c_tready : app_igr_tready;
        end while (!ready);
        #5;
        if (from_h2c) begin
            h2c_tvalid = 1'b0;
        end else begin
            app_igr_tvalid = 1'b0;
        end
    endtask

    task automatic send_packets(input logic from_h2c, input int count);
        axis_beat_t  beat;
        logic [31:0] r;
        int unsigned len;
        logic        to_c2h;
        repeat (count) begin
            r              = next_rand();
            len            = 1 + r[31:30];
            beat.tdest     = r[27:24];
            beat.tuser.pid = r[23:8];
            beat.tid       = from_h2c ? 4'd1 : 4'd0;
            beat.tkeep     = '1;
            // App packets forced to c2h or sent there by tdest bit 0
            to_c2h = !from_h2c && ((ovr.enable && ovr.value) || (!ovr.enable && beat.tdest[0]));
            for (int i = 0; i < len; i++) begin
                beat.tdata = {next_rand(), next_rand()};
                beat.tlast = (i == len - 1);
                if (to_c2h) begin
                    c2h_q.push_back(beat);
                end else if (from_h2c) begin
                    egr_h2c_q.push_back(beat);
                end else begin
                    egr_igr_q.push_back(beat);
                end
                drive_beat(from_h2c, beat);
            end
        end
    endtask

    task automatic wait_drain();
        while (egr_igr_q.size() + egr_h2c_q.size() + c2h_q.size() > 0) begin
            @(posedge core_clk);
        end
        #5;
    endtask

    // ------------------------------------------------------------
    // Clock, output ready and monitors
    // ------------------------------------------------------------
    initial begin
        core_clk = 1'b0;
        forever #50 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        #5;
        app_egr_tready = coin_flip();
        c2h_tready     = coin_flip();
    end

    always @(posedge core_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_fail("Timeout: the outputs did not drain within the cycle limit");
        end
        if (smartnic_app_i.smartnic_app_chk_i.error_count != 0) begin
            report_fail("A protocol assertion on the DUT outputs failed");
        end
        if (!reset && app_egr_tvalid && app_egr_tready) begin
            check_egr_beat();
        end
        if (!reset && c2h_tvalid && c2h_tready) begin
            check_c2h_beat();
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        reset          = 1'b1;
        reg_wr         = 1'b0;
        reg_addr       = REG_IGR_DEMUX_SEL;
        reg_wdata      = '0;
        app_igr_beat   = '0;
        app_igr_tvalid = 1'b0;
        h2c_beat       = '0;
        h2c_tvalid     = 1'b0;
        app_egr_tready = 1'b0;
        c2h_tready     = 1'b0;
        ovr            = '0;
        repeat (16) @(posedge core_clk);
        #5;
        reset = 1'b0;
        check_reg(32'h0);

        // Routing by tdest
        send_packets(1'b0, 20);
        wait_drain();

        // Forced to c2h and then to app_egr
        write_reg(REG_IGR_DEMUX_SEL, 32'h3);
        check_reg(32'h3);
        send_packets(1'b0, 10);
        wait_drain();
        write_reg(REG_IGR_DEMUX_SEL, 32'h1);
        check_reg(32'h1);
        send_packets(1'b0, 10);
        wait_drain();

        // Both sources at once into the mux
        write_reg(REG_IGR_DEMUX_SEL, 32'h0);
        check_reg(32'h0);
        fork
            send_packets(1'b0, 10);
            send_packets(1'b1, 10);
        join
        wait_drain();

        repeat (4) @(posedge core_clk);
        if (app_egr_tvalid || c2h_tvalid) begin
            report_fail("An output still offers a beat after all packets were received");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

//--- tb.f
verilog/smartnic_app_pkg.sv
verilog/app_ctrl.sv
verilog/axis_fifo_sync.sv
verilog/axis_demux.sv
verilog/axis_mux.sv
verilog/smartnic_app.sv
verif/smartnic_app_chk.sv
verif/smartnic_app_tb.sv

//--- Bender.yml
package:
  name: smartnic_app

sources:
  - files:
      - verilog/smartnic_app_pkg.sv
      - verilog/app_ctrl.sv
      - verilog/axis_fifo_sync.sv
      - verilog/axis_demux.sv
      - verilog/axis_mux.sv
      - verilog/smartnic_app.sv
  - target: test
    files:
      - verif/smartnic_app_chk.sv
      - verif/smartnic_app_tb.sv
